/* logic/raster_pkg.sv */
package raster_pkg;

    localparam int addr_width = 26;
    localparam int data_width = 32;
    localparam int record_words = 15;

    // x and y are signed 16.16 fixed point
    typedef struct packed {
        logic [data_width-1:0] x;
        logic [data_width-1:0] y;
        logic [data_width-1:0] z;
        logic [data_width-1:0] color;
    } vertex_t;

    typedef struct packed {
        vertex_t [2:0] vertex;
        logic [2:0][data_width-1:0] attr;
    } tri_record_t;

    typedef struct packed {
        logic signed [15:0] min_x;
        logic signed [15:0] max_x;
        logic signed [15:0] min_y;
        logic signed [15:0] max_y;
    } bbox_t;

    typedef struct packed {
        tri_record_t record;
        bbox_t bbox;
    } raster_tri_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic [31:0] tri_total;
        logic [31:0] tri_emitted;
    } fetch_status_t;

    typedef enum logic [1:0] {fetch_idle, fetch_header, fetch_record} fetch_state_e;

    typedef enum logic {recv_header, recv_record} recv_state_e;

    typedef enum logic [7:0] {
        reg_control = 8'h00,
        reg_base = 8'h04,
        reg_status = 8'h08,
        reg_total = 8'h0c,
        reg_emitted = 8'h10
    } reg_addr_e;

endpackage

/* logic/triangle_fifo.sv */
`timescale 1ns/1ns

module triangle_fifo #(
    parameter int fifo_depth_log2 = 2
) (
    input  logic clock,
    input  logic reset,
    input  logic push,
    input  raster_pkg::tri_record_t push_data,
    input  logic pop,
    output raster_pkg::tri_record_t head,
    output logic empty,
    output logic [fifo_depth_log2:0] free_slots
);
    import raster_pkg::*;

    localparam int depth = 1 << fifo_depth_log2;
    localparam logic [fifo_depth_log2:0] depth_slots = (fifo_depth_log2 + 1)'(depth);

    tri_record_t slots [depth];
    logic [fifo_depth_log2-1:0] wr_ptr;
    logic [fifo_depth_log2-1:0] rd_ptr;
    logic [fifo_depth_log2:0] count;
    logic full;
    logic do_push;
    logic do_pop;

    assign empty = (count == '0);
    assign full = (count == depth_slots);
    assign free_slots = depth_slots - count;
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // Show-ahead output
    assign head = slots[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* logic/vertex_fetch.sv */
`timescale 1ns/1ns

module vertex_fetch #(
    parameter int fifo_depth_log2 = 2
) (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic [raster_pkg::addr_width-1:0] base,

    output logic [raster_pkg::addr_width-1:0] mem_address,
    output logic mem_read,
    input  logic [raster_pkg::data_width-1:0] mem_readdata,
    input  logic mem_readdatavalid,
    input  logic mem_waitrequest,

    output raster_pkg::fetch_status_t status,
    output raster_pkg::tri_record_t fifo_head,
    output logic fifo_empty,
    input  logic pop
);
    import raster_pkg::*;

    localparam int count_width = fifo_depth_log2 + 1;

    fetch_state_e req_state;
    recv_state_e recv_state;
    logic [3:0] req_words;
    logic [3:0] recv_words;
    logic [31:0] tri_requested;
    logic [31:0] tri_total;
    logic [31:0] tri_emitted;
    logic [count_width-1:0] in_flight;
    logic [count_width-1:0] free_slots;
    logic header_valid;
    logic launched;
    logic start_accept;
    logic slot_free;
    logic record_start;
    logic done;
    logic push;
    tri_record_t record_buf;

    assign start_accept = start && (req_state == fetch_idle);
    // A slot counts as taken from the first request of a record until it is popped
    assign slot_free = in_flight < free_slots;
    assign record_start = (req_state == fetch_record) && !mem_read && header_valid
        && (tri_requested < tri_total) && slot_free;

    assign done = header_valid && (tri_emitted == tri_total);

    always_comb begin
        status.busy = launched && !done;
        status.done = done;
        status.tri_total = tri_total;
        status.tri_emitted = tri_emitted;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            req_state <= fetch_idle;
            mem_read <= 1'b0;
            mem_address <= '0;
            req_words <= '0;
            tri_requested <= '0;
        end else begin
            case (req_state)
                fetch_idle: begin
                    if (start_accept) begin
                        mem_address <= base;
                        mem_read <= 1'b1;
                        tri_requested <= '0;
                        req_state <= fetch_header;
                    end
                end
                fetch_header: begin
                    if (!mem_waitrequest) begin
                        mem_read <= 1'b0;
                        req_state <= fetch_record;
                    end
                end
                fetch_record: begin
                    if (mem_read) begin
                        if (!mem_waitrequest) begin
                            if (req_words == 4'(record_words - 1)) begin
                                mem_read <= 1'b0;
                                req_words <= '0;
                            end else begin
                                mem_address <= mem_address + addr_width'(4);
                                req_words <= req_words + 4'd1;
                            end
                        end
                    end else if (record_start) begin
                        mem_address <= mem_address + addr_width'(4);
                        mem_read <= 1'b1;
                        tri_requested <= tri_requested + 32'd1;
                    end else if (header_valid && tri_requested == tri_total) begin
                        req_state <= fetch_idle;
                    end
                end
                default: req_state <= fetch_idle;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            in_flight <= '0;
        end else begin
            case ({record_start, push})
                2'b10: in_flight <= in_flight + count_width'(1);
                2'b01: in_flight <= in_flight - count_width'(1);
                default: in_flight <= in_flight;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            recv_state <= recv_header;
            recv_words <= '0;
            header_valid <= 1'b0;
            tri_total <= '0;
            tri_emitted <= '0;
            launched <= 1'b0;
            push <= 1'b0;
        end else begin
            push <= 1'b0;
            if (start_accept) begin
                recv_state <= recv_header;
                recv_words <= '0;
                header_valid <= 1'b0;
                tri_total <= '0;
                tri_emitted <= '0;
                launched <= 1'b1;
            end else begin
                if (pop && !fifo_empty) begin
                    tri_emitted <= tri_emitted + 32'd1;
                end
                if (mem_readdatavalid) begin
                    if (recv_state == recv_header) begin
                        tri_total <= mem_readdata;
                        header_valid <= 1'b1;
                        recv_state <= recv_record;
                    end else if (recv_words == 4'(record_words - 1)) begin
                        recv_words <= '0;
                        push <= 1'b1;
                    end else begin
                        recv_words <= recv_words + 4'd1;
                    end
                end
            end
        end
    end

    // Words 0 to 11 are the vertices in x, y, z, color order, then three attributes
    always_ff @(posedge clock) begin
        if (mem_readdatavalid && recv_state == recv_record) begin
            if (recv_words < 4'd12) begin
                case (recv_words[1:0])
                    2'd0: record_buf.vertex[recv_words[3:2]].x <= mem_readdata;
                    2'd1: record_buf.vertex[recv_words[3:2]].y <= mem_readdata;
                    2'd2: record_buf.vertex[recv_words[3:2]].z <= mem_readdata;
                    default: record_buf.vertex[recv_words[3:2]].color <= mem_readdata;
                endcase
            end else begin
                record_buf.attr[2'(recv_words - 4'd12)] <= mem_readdata;
            end
        end
    end

    triangle_fifo #(
        .fifo_depth_log2(fifo_depth_log2)
    ) fifo (
        .clock(clock),
        .reset(reset),
        .push(push),
        .push_data(record_buf),
        .pop(pop),
        .head(fifo_head),
        .empty(fifo_empty),
        .free_slots(free_slots)
    );

endmodule

/* logic/triangle_setup.sv */
`timescale 1ns/1ns

module triangle_setup (
    input  logic clock,
    input  logic reset,
    input  raster_pkg::tri_record_t head,
    input  logic empty,
    output logic pop,
    output raster_pkg::raster_tri_t tri_out,
    output logic tri_valid,
    input  logic stall
);
    import raster_pkg::*;

    bbox_t box;
    logic signed [15:0] x [3];
    logic signed [15:0] y [3];

    function automatic logic signed [15:0] min3(input logic signed [15:0] a,
                                                input logic signed [15:0] b,
                                                input logic signed [15:0] c);
        logic signed [15:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic signed [15:0] max3(input logic signed [15:0] a,
                                                input logic signed [15:0] b,
                                                input logic signed [15:0] c);
        logic signed [15:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // Integer part of 16.16
    always_comb begin
        for (int v = 0; v < 3; v++) begin
            x[v] = head.vertex[v].x[31:16];
            y[v] = head.vertex[v].y[31:16];
        end
        box.min_x = min3(x[0], x[1], x[2]);
        box.max_x = max3(x[0], x[1], x[2]);
        box.min_y = min3(y[0], y[1], y[2]);
        box.max_y = max3(y[0], y[1], y[2]);
    end

    assign pop = !empty && (!tri_valid || !stall);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            tri_valid <= 1'b0;
        end else if (pop) begin
            tri_valid <= 1'b1;
        end else if (!stall) begin
            tri_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            tri_out.record <= head;
            tri_out.bbox <= box;
        end
    end

endmodule

/* logic/raster_ctrl_regs.sv */
`timescale 1ns/1ns

module raster_ctrl_regs (
    input  logic clock,
    input  logic reset,

    input  logic [7:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [raster_pkg::data_width-1:0] wdata,
    input  logic [raster_pkg::data_width/8-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [7:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [raster_pkg::data_width-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,

    output logic start,
    output logic [raster_pkg::addr_width-1:0] base,
    input  raster_pkg::fetch_status_t status
);
    import raster_pkg::*;

    logic write_fire;
    logic read_fire;

    assign write_fire = awready && awvalid && wready && wvalid;
    assign read_fire = arready && arvalid;

    // OKAY on every response
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            start <= 1'b0;
            base <= '0;
        end else begin
            start <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            // Address and data are taken together, one cycle after both show up
            if (awvalid && wvalid && !awready && !bvalid) begin
                awready <= 1'b1;
                wready <= 1'b1;
            end
            if (write_fire) begin
                bvalid <= 1'b1;
                if (awaddr == reg_control && wstrb[0] && wdata[0] && !status.busy) begin
                    start <= 1'b1;
                end
                if (awaddr == reg_base) begin
                    for (int b = 0; b < addr_width; b++) begin
                        if (wstrb[b / 8]) begin
                            base[b] <= wdata[b];
                        end
                    end
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else if (read_fire) begin
            arready <= 1'b0;
            rvalid <= 1'b1;
        end else if (rvalid) begin
            if (rready) begin
                rvalid <= 1'b0;
                arready <= 1'b1;
            end
        end else begin
            arready <= 1'b1;
        end
    end

    // Control reads back as zero, like any unmapped offset
    always_ff @(posedge clock) begin
        if (read_fire) begin
            case (araddr)
                reg_base: rdata <= data_width'(base);
                reg_status: rdata <= data_width'({status.done, status.busy});
                reg_total: rdata <= status.tri_total;
                reg_emitted: rdata <= status.tri_emitted;
                default: rdata <= '0;
            endcase
        end
    end

endmodule

/* logic/raster_front.sv */
`timescale 1ns/1ns

module raster_front #(
    parameter int fifo_depth_log2 = 2
) (
    input  logic clock,
    input  logic reset,

    input  logic [7:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [raster_pkg::data_width-1:0] wdata,
    input  logic [raster_pkg::data_width/8-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [7:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [raster_pkg::data_width-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,

    output logic [raster_pkg::addr_width-1:0] mem_address,
    output logic mem_read,
    input  logic [raster_pkg::data_width-1:0] mem_readdata,
    input  logic mem_readdatavalid,
    input  logic mem_waitrequest,

    output raster_pkg::raster_tri_t tri_out,
    output logic tri_valid,
    input  logic stall
);
    import raster_pkg::*;

    logic start;
    logic [addr_width-1:0] base;
    fetch_status_t status;
    tri_record_t fifo_head;
    logic fifo_empty;
    logic pop;

    raster_ctrl_regs regs (
        .clock(clock),
        .reset(reset),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .start(start),
        .base(base),
        .status(status)
    );

    vertex_fetch #(
        .fifo_depth_log2(fifo_depth_log2)
    ) fetch (
        .clock(clock),
        .reset(reset),
        .start(start),
        .base(base),
        .mem_address(mem_address),
        .mem_read(mem_read),
        .mem_readdata(mem_readdata),
        .mem_readdatavalid(mem_readdatavalid),
        .mem_waitrequest(mem_waitrequest),
        .status(status),
        .fifo_head(fifo_head),
        .fifo_empty(fifo_empty),
        .pop(pop)
    );

    triangle_setup setup (
        .clock(clock),
        .reset(reset),
        .head(fifo_head),
        .empty(fifo_empty),
        .pop(pop),
        .tri_out(tri_out),
        .tri_valid(tri_valid),
        .stall(stall)
    );

endmodule

/* verification/vertex_memory_model.sv */
`timescale 1ns/1ns

module vertex_memory_model #(
    parameter int mem_words_log2 = 12,
    parameter int seed_init = 32'hc6ee
) (
    input  logic clock,
    input  logic reset,
    input  logic [raster_pkg::addr_width-1:0] address,
    input  logic read,
    output logic [raster_pkg::data_width-1:0] readdata,
    output logic readdatavalid,
    output logic waitrequest
);
    import raster_pkg::*;

    localparam int mem_words = 1 << mem_words_log2;

    logic [data_width-1:0] words [mem_words];
    logic [mem_words_log2-1:0] pending_index [$];
    int unsigned pending_due [$];
    int unsigned cycle;
    int unsigned last_due;
    int seed = seed_init;

    // Words never loaded carry a pattern of their own index
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            words[i] = {16'(~i), 16'(i)};
        end
    end

    always @(posedge clock or negedge reset) begin : respond
        int unsigned due;
        if (!reset) begin
            waitrequest <= 1'b1;
            readdatavalid <= 1'b0;
            readdata <= '0;
            cycle <= 0;
            last_due = 0;
            pending_index.delete();
            pending_due.delete();
        end else begin
            cycle <= cycle + 1;
            readdatavalid <= 1'b0;
            // Roughly one cycle in four holds the master off
            waitrequest <= (($random(seed) & 3) == 0);
            if (read && !waitrequest) begin
                due = cycle + 1 + ($unsigned($random(seed)) % 4);
                // Keep returns in request order
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pending_index.push_back(address[mem_words_log2+1:2]);
                pending_due.push_back(due);
            end
            if (pending_due.size() > 0 && pending_due[0] <= cycle) begin
                readdatavalid <= 1'b1;
                readdata <= words[pending_index.pop_front()];
                void'(pending_due.pop_front());
            end
        end
    end

endmodule

/* verification/raster_front_tb.sv */
`timescale 1ns/1ns

module raster_front_tb;
    import raster_pkg::*;

    localparam int mem_words_log2 = 12;
    localparam int seed_value = 32'hc6ee;
    localparam int first_count = 6;

    logic clock;
    logic reset;
    logic [7:0] awaddr;
    logic awvalid;
    logic awready;
    logic [data_width-1:0] wdata;
    logic [data_width/8-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [7:0] araddr;
    logic arvalid;
    logic arready;
    logic [data_width-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic [addr_width-1:0] mem_address;
    logic mem_read;
    logic [data_width-1:0] mem_readdata;
    logic mem_readdatavalid;
    logic mem_waitrequest;
    raster_tri_t tri_out;
    logic tri_valid;
    logic stall = 1'b0;

    int seed = seed_value;
    int stall_seed = seed_value;
    int errors = 0;
    int tri_checked = 0;
    int unsigned cycle_count = 0;
    int unsigned timeout_start = 0;
    int unsigned timeout_limit = 1000;
    logic hold_stall = 1'b0;
    logic run_finished = 1'b0;
    raster_tri_t exp_tri [$];
    logic [addr_width-1:0] exp_addr [$];

    raster_front #(
        .fifo_depth_log2(2)
    ) dut (.*);

    vertex_memory_model #(
        .mem_words_log2(mem_words_log2),
        .seed_init(seed_value)
    ) memory (
        .clock(clock),
        .reset(reset),
        .address(mem_address),
        .read(mem_read),
        .readdata(mem_readdata),
        .readdatavalid(mem_readdatavalid),
        .waitrequest(mem_waitrequest)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        stall <= hold_stall || ($random(stall_seed) & 1);
    end

    initial begin
        do @(posedge clock); while (cycle_count - timeout_start <= timeout_limit);
        $display("Timeout: no completion within %0d cycles", timeout_limit);
        $display("Simulation FAILED");
        $finish;
    end

    assert property (@(posedge clock) disable iff (!reset)
        tri_valid && stall |=> tri_valid && $stable(tri_out))
        else begin
            errors++;
            $display("ERROR stall_hold: triangle output changed while stalled");
        end

    assert property (@(posedge clock) disable iff (!reset) bvalid && !bready |=> bvalid)
        else begin
            errors++;
            $display("ERROR axi_write: bvalid dropped before bready");
        end

    assert property (@(posedge clock) disable iff (!reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            errors++;
            $display("ERROR axi_read: read response changed before rready");
        end

    assert property (@(posedge clock) disable iff (!reset) bvalid |-> bresp == 2'b00)
        else begin
            errors++;
            $display("ERROR axi_bresp: expected 0, actual %0d", $sampled(bresp));
        end

    assert property (@(posedge clock) disable iff (!reset) rvalid |-> rresp == 2'b00)
        else begin
            errors++;
            $display("ERROR axi_rresp: expected 0, actual %0d", $sampled(rresp));
        end

    assert property (@(posedge clock) disable iff (!reset)
        mem_read && mem_waitrequest |=> mem_read && $stable(mem_address))
        else begin
            errors++;
            $display("ERROR mem_hold: read request changed under waitrequest");
        end

    assert property (@(posedge clock) disable iff (!reset) run_finished |-> !mem_read)
        else begin
            errors++;
            $display("ERROR idle_after_done: memory read issued after completion");
        end

    // Scoreboards for the read address sequence and the triangles leaving the DUT
    always @(posedge clock) begin : scoreboard
        logic [addr_width-1:0] expected_addr;
        raster_tri_t expected;
        if (reset && mem_read && !mem_waitrequest) begin
            if (exp_addr.size() == 0) begin
                errors++;
                $display("ERROR read_address: unexpected read at %h", mem_address);
            end else begin
                expected_addr = exp_addr.pop_front();
                assert (mem_address == expected_addr) else begin
                    errors++;
                    $display("ERROR read_address: expected %h, actual %h",
                             expected_addr, mem_address);
                end
            end
        end
        if (reset && tri_valid && !stall) begin
            if (exp_tri.size() == 0) begin
                errors++;
                $display("ERROR ordered_fetch: triangle transferred with none expected");
            end else begin
                expected = exp_tri.pop_front();
                assert (tri_out.record == expected.record) else begin
                    errors++;
                    $display("ERROR ordered_fetch: triangle %0d expected %h, actual %h",
                             tri_checked, expected.record, tri_out.record);
                end
                assert (tri_out.bbox == expected.bbox) else begin
                    errors++;
                    $display("ERROR bounding_box: triangle %0d expected %h, actual %h",
                             tri_checked, expected.bbox, tri_out.bbox);
                end
            end
            tri_checked <= tri_checked + 1;
        end
    end

    function automatic bbox_t bounding_box(input tri_record_t rec);
        bbox_t box;
        logic signed [15:0] ix;
        logic signed [15:0] iy;
        for (int v = 0; v < 3; v++) begin
            ix = rec.vertex[v].x[31:16];
            iy = rec.vertex[v].y[31:16];
            if (v == 0 || ix < box.min_x) box.min_x = ix;
            if (v == 0 || ix > box.max_x) box.max_x = ix;
            if (v == 0 || iy < box.min_y) box.min_y = iy;
            if (v == 0 || iy > box.max_y) box.max_y = iy;
        end
        return box;
    endfunction

    task automatic arm_timeout(input int unsigned limit);
        timeout_start <= cycle_count;
        timeout_limit <= limit;
    endtask

    task automatic store_word(input logic [addr_width-1:0] addr, input logic [31:0] data);
        memory.words[int'(addr >> 2)] = data;
    endtask

    // Header at the base, then n records; fills both scoreboards
    task automatic load_buffer(input logic [addr_width-1:0] buf_base, input int n);
        tri_record_t rec;
        raster_tri_t expected;
        logic [addr_width-1:0] addr;
        logic [31:0] word;
        store_word(buf_base, 32'(n));
        exp_addr.push_back(buf_base);
        addr = buf_base;
        for (int t = 0; t < n; t++) begin
            for (int w = 0; w < record_words; w++) begin
                addr = addr + addr_width'(4);
                word = $random(seed);
                // First triangle always has a negative x and y
                if (t == 0 && (w == 4 || w == 1)) word[31] = 1'b1;
                if (w < 12) begin
                    case (w % 4)
                        0: rec.vertex[w / 4].x = word;
                        1: rec.vertex[w / 4].y = word;
                        2: rec.vertex[w / 4].z = word;
                        default: rec.vertex[w / 4].color = word;
                    endcase
                end else begin
                    rec.attr[w - 12] = word;
                end
                store_word(addr, word);
                exp_addr.push_back(addr);
            end
            expected.record = rec;
            expected.bbox = bounding_box(rec);
            exp_tri.push_back(expected);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clock);
        awaddr <= addr;
        awvalid <= 1'b1;
        wdata <= data;
        wstrb <= '1;
        wvalid <= 1'b1;
        do @(posedge clock); while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        do @(posedge clock); while (!bvalid);
        // Leave the response waiting one cycle
        @(posedge clock);
        bready <= 1'b1;
        @(posedge clock);
        bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clock);
        araddr <= addr;
        arvalid <= 1'b1;
        do @(posedge clock); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clock); while (!rvalid);
        @(posedge clock);
        rready <= 1'b1;
        @(posedge clock);
        data = rdata;
        rready <= 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_status_done(output logic [31:0] word);
        do read_reg(reg_status, word); while (!word[1]);
    endtask

    initial begin : main
        logic [31:0] word;
        logic [addr_width-1:0] base_a;
        logic [addr_width-1:0] base_b;
        reset = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b1;

        arm_timeout(400);
        read_reg(reg_status, word);
        check_value("status_after_reset", 32'h0, word);
        write_reg(reg_base, 32'hffff_fff0);
        read_reg(reg_base, word);
        check_value("base_readback", 32'hffff_fff0 & ((32'd1 << addr_width) - 1), word);
        read_reg(8'h14, word);
        check_value("unmapped_read", 32'h0, word);
        read_reg(8'h3c, word);
        check_value("unmapped_read", 32'h0, word);

        // Stall held at first so the FIFO fills, then random
        arm_timeout((first_count + 1) * record_words * 20 + 500);
        base_a = addr_width'((16 + ($unsigned($random(seed)) % 2048)) * 4);
        load_buffer(base_a, first_count);
        hold_stall <= 1'b1;
        write_reg(reg_base, 32'(base_a));
        write_reg(reg_control, 32'h1);
        read_reg(reg_status, word);
        check_value("busy_after_start", 32'h1, word);
        write_reg(reg_control, 32'h1);
        repeat (300) @(posedge clock);
        hold_stall <= 1'b0;
        do @(posedge clock); while (tri_checked < first_count);
        wait_status_done(word);
        check_value("status_done", 32'h2, word);
        read_reg(reg_total, word);
        check_value("tri_total", 32'(first_count), word);
        read_reg(reg_emitted, word);
        check_value("tri_emitted", 32'(first_count), word);
        run_finished <= 1'b1;
        repeat (20) @(posedge clock);
        check_value("reads_left", 32'h0, exp_addr.size());
        check_value("triangles_seen", 32'(first_count), tri_checked);

        arm_timeout(record_words * 20 + 500);
        run_finished <= 1'b0;
        base_b = addr_width'((2400 + ($unsigned($random(seed)) % 1024)) * 4);
        load_buffer(base_b, 0);
        write_reg(reg_base, 32'(base_b));
        write_reg(reg_control, 32'h1);
        wait_status_done(word);
        check_value("empty_status_done", 32'h2, word);
        read_reg(reg_total, word);
        check_value("empty_tri_total", 32'h0, word);
        read_reg(reg_emitted, word);
        check_value("empty_tri_emitted", 32'h0, word);
        run_finished <= 1'b1;
        repeat (20) @(posedge clock);
        check_value("empty_reads_left", 32'h0, exp_addr.size());
        check_value("triangles_seen", 32'(first_count), tri_checked);

        $display("Checks complete: %0d triangles transferred, %0d errors", tri_checked, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
logic/raster_pkg.sv
logic/triangle_fifo.sv
logic/vertex_fetch.sv
logic/triangle_setup.sv
logic/raster_ctrl_regs.sv
logic/raster_front.sv
verification/vertex_memory_model.sv
verification/raster_front_tb.sv

/* Bender.yml */
package:
  name: raster_front

sources:
  - logic/raster_pkg.sv
  - logic/triangle_fifo.sv
  - logic/vertex_fetch.sv
  - logic/triangle_setup.sv
  - logic/raster_ctrl_regs.sv
  - logic/raster_front.sv
  - target: test
    files:
      - verification/vertex_memory_model.sv
      - verification/raster_front_tb.sv
